/* hdl/bram_bank.sv */
// one RAM bank: 128-bit lines, 64-bit lane writes with byte enables, lane read select

`timescale 1ns/1ns

module bram_bank (
   input  logic                 ram_clk,
   input  logic                 rst_i,
   input  logic                 bank_stb_i,
   input  logic                 wb_we_i,
   input  bram_io_pkg::wb_adr_t wb_adr_i,
   input  bram_io_pkg::wb_dat_t wb_dat_i,
   input  bram_io_pkg::wb_sel_t wb_sel_i,
   output logic                 bank_ack_o,
   output bram_io_pkg::wb_dat_t bank_dat_o
);

   import bram_io_pkg::*;

   // storage
   line_t                ram [2**LINE_BITS];

   logic [LINE_BITS-1:0] line_idx;
   logic [LINE_BITS-1:0] line_idx_q;
   logic [LANE_BITS-1:0] lane;
   logic [LANE_BITS-1:0] lane_q;
   logic                 ram_en;
   line_sel_t            we_full;
   line_t                wr_full;
   line_t                rd_full;

   ////////////////////
   // address split

   assign line_idx = wb_adr_i[BANK_SIZE_LOG2-1 : OFFSET_BITS+LANE_BITS];
   assign lane     = wb_adr_i[OFFSET_BITS +: LANE_BITS];

   // one access per strobed request, the ack cycle is not a new access
   assign ram_en = bank_stb_i & ~bank_ack_o;

   ////////////////////
   // write path

   // selects move up by one word's worth of bytes for the upper lane
   assign we_full = wb_we_i ? (line_sel_t'(wb_sel_i) << {lane, {OFFSET_BITS{1'b0}}}) : '0;

   assign wr_full = {(2**LANE_BITS){wb_dat_i}};   // same word in both lanes

   always_ff @(posedge ram_clk) begin
      if (ram_en) begin
         line_idx_q <= line_idx;
         lane_q     <= lane;
         foreach (we_full[i]) begin
            if (we_full[i]) begin
               ram[line_idx][i*8 +: 8] <= wr_full[i*8 +: 8];
            end
         end
      end
   end

   ////////////////////
   // read path

   // line address was captured at the strobe, so the lane is picked a cycle later
   assign rd_full    = ram[line_idx_q];
   assign bank_dat_o = rd_full[lane_q*DAT_BYTES*8 +: DAT_BYTES*8];

   ////////////////////
   // acknowledge

   always_ff @(posedge ram_clk) begin
      if (rst_i) begin
         bank_ack_o <= 1'b0;
      end else begin
         bank_ack_o <= ram_en;   // single pulse even if stb stays up
      end
   end

   ////////////////////
   // checks

   // master holding stb through the ack must not get a second response
   assert property (@(posedge ram_clk) disable iff (rst_i)
      bank_ack_o |=> !bank_ack_o)
      else $error("bank ack high two cycles in a row");

endmodule

/* hdl/bram_io_pkg.sv */
// bus word types, RAM line types, bank geometry and the bank address map

package bram_io_pkg;

   ////////////////////
   // bus widths

   typedef logic [31:0]  wb_adr_t;    // byte address
   typedef logic [63:0]  wb_dat_t;    // one bus word
   typedef logic [7:0]   wb_sel_t;    // byte selects of one word

   // a RAM line holds two bus words
   typedef logic [127:0] line_t;
   typedef logic [15:0]  line_sel_t;  // byte enables over a whole line

   localparam int DAT_BYTES   = 8;
   localparam int OFFSET_BITS = 3;    // byte within a word
   localparam int LANE_BITS   = 1;    // word within a line

   ////////////////////
   // bank geometry

   // 4 KB per bank, 256 lines of 16 bytes
   localparam int BANK_SIZE_LOG2 = 12;
   localparam int LINE_BITS      = 8;
   localparam int NUM_BANK       = 3;

   ////////////////////
   // address map

   // bank 0 sits in the lowest slot
   localparam wb_adr_t [NUM_BANK-1:0] BANK_BASE = {
      32'h0002_0000,
      32'h0001_0000,
      32'h0000_0000
   };

   // banks are spaced 64 KB apart, only the low 4 KB of each window decodes
   localparam wb_adr_t [NUM_BANK-1:0] BANK_MASK = {
      32'hFFFF_F000,
      32'hFFFF_F000,
      32'hFFFF_F000
   };

endpackage

/* hdl/bram_io_top.sv */
// top level: Wishbone slave port, address decoder, RAM banks, response collector

`timescale 1ns/1ns

module bram_io_top (
   input  logic                 ram_clk,
   input  logic                 rst_i,

   // wishbone classic slave
   input  logic                 wb_cyc_i,
   input  logic                 wb_stb_i,
   input  logic                 wb_we_i,
   input  bram_io_pkg::wb_adr_t wb_adr_i,
   input  bram_io_pkg::wb_dat_t wb_dat_i,
   input  bram_io_pkg::wb_sel_t wb_sel_i,
   output logic                 wb_ack_o,
   output logic                 wb_err_o,
   output bram_io_pkg::wb_dat_t wb_dat_o
);

   import bram_io_pkg::*;

   logic [NUM_BANK-1:0] bank_stb;
   logic                miss_stb;
   logic [NUM_BANK-1:0] bank_ack;
   wb_dat_t             bank_dat [NUM_BANK];

   ////////////////////
   // decode

   io_addr_decoder addr_dec (
      .wb_cyc_i    ( wb_cyc_i   ),
      .wb_stb_i    ( wb_stb_i   ),
      .wb_adr_i    ( wb_adr_i   ),
      .bank_stb_o  ( bank_stb   ),
      .miss_stb_o  ( miss_stb   )
   );

   ////////////////////
   // banks

   // every bank sees the full request, only its strobe differs
   for (genvar g = 0; g < NUM_BANK; g++) begin : g_bank
      bram_bank bank (
         .ram_clk     ( ram_clk      ),
         .rst_i       ( rst_i        ),
         .bank_stb_i  ( bank_stb[g]  ),
         .wb_we_i     ( wb_we_i      ),
         .wb_adr_i    ( wb_adr_i     ),
         .wb_dat_i    ( wb_dat_i     ),
         .wb_sel_i    ( wb_sel_i     ),
         .bank_ack_o  ( bank_ack[g]  ),
         .bank_dat_o  ( bank_dat[g]  )
      );
   end

   ////////////////////
   // responses

   io_resp_mux resp_mux (
      .ram_clk     ( ram_clk    ),
      .rst_i       ( rst_i      ),
      .bank_ack_i  ( bank_ack   ),
      .bank_dat_i  ( bank_dat   ),
      .miss_stb_i  ( miss_stb   ),
      .wb_ack_o    ( wb_ack_o   ),
      .wb_err_o    ( wb_err_o   ),
      .wb_dat_o    ( wb_dat_o   )
   );

endmodule

/* hdl/io_addr_decoder.sv */
// address decoder: base/mask match per bank, bank strobes and miss strobe

`timescale 1ns/1ns

module io_addr_decoder (
   input  logic                             wb_cyc_i,
   input  logic                             wb_stb_i,
   input  bram_io_pkg::wb_adr_t             wb_adr_i,
   output logic [bram_io_pkg::NUM_BANK-1:0] bank_stb_o,
   output logic                             miss_stb_o
);

   import bram_io_pkg::*;

   logic                req;
   logic [NUM_BANK-1:0] hit;

   assign req = wb_cyc_i & wb_stb_i;

   ////////////////////
   // match against the map

   always_comb begin
      for (int i = 0; i < NUM_BANK; i++) begin
         hit[i] = (wb_adr_i & BANK_MASK[i]) == BANK_BASE[i];
      end
   end

   assign bank_stb_o = hit & {NUM_BANK{req}};
   assign miss_stb_o = req & ~(|hit);   // strobed but nobody claims it

   ////////////////////
   // checks

   // two banks claiming one request would mean overlapping windows in the map
   always_comb begin
      assert ($onehot0(bank_stb_o))
         else $error("bank strobes not one-hot, address map overlaps at %h", wb_adr_i);
   end

endmodule

/* hdl/io_resp_mux.sv */
// response collector: ack OR, read data select, error pulse for unmapped addresses

`timescale 1ns/1ns

module io_resp_mux (
   input  logic                             ram_clk,
   input  logic                             rst_i,
   input  logic [bram_io_pkg::NUM_BANK-1:0] bank_ack_i,
   input  bram_io_pkg::wb_dat_t             bank_dat_i [bram_io_pkg::NUM_BANK],
   input  logic                             miss_stb_i,
   output logic                             wb_ack_o,
   output logic                             wb_err_o,
   output bram_io_pkg::wb_dat_t             wb_dat_o
);

   import bram_io_pkg::*;

   assign wb_ack_o = |bank_ack_i;

   // and-or select, zero when nobody answers
   always_comb begin
      wb_dat_o = '0;
      for (int i = 0; i < NUM_BANK; i++) begin
         if (bank_ack_i[i]) begin
            wb_dat_o = wb_dat_o | bank_dat_i[i];
         end
      end
   end

   ////////////////////
   // error response

   always_ff @(posedge ram_clk) begin
      if (rst_i) begin
         wb_err_o <= 1'b0;
      end else begin
         wb_err_o <= miss_stb_i & ~wb_err_o;   // same pulse rule as the banks
      end
   end

   ////////////////////
   // checks

   // a request is either mapped or not, never both
   assert property (@(posedge ram_clk) disable iff (rst_i)
      !(wb_ack_o && wb_err_o))
      else $error("ack and err high together");

   // only one request in flight, so at most one bank may answer
   assert property (@(posedge ram_clk) disable iff (rst_i)
      $onehot0(bank_ack_i))
      else $error("more than one bank acknowledged");

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the bram_io testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_bram_io

verilator --binary --timing --assert -j 0 \
   --top-module "$TOP" \
   -f verilog.f \
   -Mdir "$BUILD_DIR" \
   -o "V$TOP"
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
   exit 0
fi
echo "simulation reported errors, see $LOG"
exit 1

/* sim/tb_vectors.svh */
// testbench constants, stimulus/expected-value table and its loader tasks

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int          CLK_PERIOD   = 4;
localparam int          RST_CYCLES   = 3;
localparam int          RESP_TIMEOUT = 16;             // cycles
localparam int          RESP_LATENCY = 2;              // sample points from drive to response
localparam logic [31:0] SEED_INIT    = 32'h42835688;

// columns: name, write, random data, address, data, selects, expected read data, expected err
string   vec_name [$];
logic    vec_we   [$];
logic    vec_rnd  [$];
wb_adr_t vec_adr  [$];
wb_dat_t vec_dat  [$];
wb_sel_t vec_sel  [$];
wb_dat_t vec_exp  [$];
logic    vec_err  [$];

task automatic add_vec(input string name, input logic we, input logic rnd, input wb_adr_t adr,
                       input wb_dat_t dat, input wb_sel_t sel, input wb_dat_t exp_dat,
                       input logic exp_err);
   vec_name.push_back(name);
   vec_we.push_back(we);
   vec_rnd.push_back(rnd);
   vec_adr.push_back(adr);
   vec_dat.push_back(dat);
   vec_sel.push_back(sel);
   vec_exp.push_back(exp_dat);
   vec_err.push_back(exp_err);
endtask

task automatic load_vectors();
   ////////////////////
   // full words, same offset in every bank
   add_vec("wr_bank0_word", 1, 0, 32'h0000_0010, 64'h0123_4567_89AB_CDEF, 8'hFF, '0, 0);
   add_vec("wr_bank1_word", 1, 0, 32'h0001_0010, 64'hFEDC_BA98_7654_3210, 8'hFF, '0, 0);
   add_vec("wr_bank2_word", 1, 0, 32'h0002_0010, 64'h5A5A_0F0F_A5A5_F0F0, 8'hFF, '0, 0);
   add_vec("rd_bank0_word", 0, 0, 32'h0000_0010, '0, 8'hFF, 64'h0123_4567_89AB_CDEF, 0);
   add_vec("rd_bank1_word", 0, 0, 32'h0001_0010, '0, 8'hFF, 64'hFEDC_BA98_7654_3210, 0);
   add_vec("rd_bank2_word", 0, 0, 32'h0002_0010, '0, 8'hFF, 64'h5A5A_0F0F_A5A5_F0F0, 0);
   ////////////////////
   // byte selects
   add_vec("wr_sel_base",   1, 0, 32'h0000_0020, 64'h1111_1111_1111_1111, 8'hFF, '0, 0);
   add_vec("wr_sel_low",    1, 0, 32'h0000_0020, 64'hAAAA_AAAA_BBBB_BBBB, 8'h0F, '0, 0);
   add_vec("rd_sel_low",    0, 0, 32'h0000_0020, '0, 8'hFF, 64'h1111_1111_BBBB_BBBB, 0);
   add_vec("wr_sel_odd",    1, 0, 32'h0000_0020, 64'hCCDD_EEFF_0011_2233, 8'hA0, '0, 0);
   add_vec("rd_sel_odd",    0, 0, 32'h0000_0020, '0, 8'hFF, 64'hCC11_EE11_BBBB_BBBB, 0);
   ////////////////////
   // both lanes of one line
   add_vec("wr_lane0",      1, 0, 32'h0000_0030, 64'hDEAD_BEEF_0000_0030, 8'hFF, '0, 0);
   add_vec("wr_lane1",      1, 0, 32'h0000_0038, 64'hCAFE_F00D_0000_0038, 8'hFF, '0, 0);
   add_vec("rd_lane0",      0, 0, 32'h0000_0030, '0, 8'hFF, 64'hDEAD_BEEF_0000_0030, 0);
   add_vec("rd_lane1",      0, 0, 32'h0000_0038, '0, 8'hFF, 64'hCAFE_F00D_0000_0038, 0);
   add_vec("wr_lane1_sel",  1, 0, 32'h0000_0038, 64'h0000_0000_0000_0077, 8'h01, '0, 0);
   add_vec("rd_lane1_sel",  0, 0, 32'h0000_0038, '0, 8'hFF, 64'hCAFE_F00D_0000_0077, 0);
   add_vec("rd_lane0_again", 0, 0, 32'h0000_0030, '0, 8'hFF, 64'hDEAD_BEEF_0000_0030, 0);
   ////////////////////
   // random data, expected values from the shadow model
   add_vec("wr_rand_bank2_top", 1, 1, 32'h0002_0FF8, '0, 8'hFF, '0, 0);
   add_vec("wr_rand_bank1_top", 1, 1, 32'h0001_0FF8, '0, 8'hFF, '0, 0);
   add_vec("wr_rand_part",      1, 1, 32'h0002_0FF8, '0, 8'h3C, '0, 0);
   add_vec("rd_rand_bank2_top", 0, 1, 32'h0002_0FF8, '0, 8'hFF, '0, 0);
   add_vec("rd_rand_bank1_top", 0, 1, 32'h0001_0FF8, '0, 8'hFF, '0, 0);
   ////////////////////
   // unmapped addresses
   add_vec("rd_unmapped_gap", 0, 0, 32'h0000_1000, '0, 8'hFF, '0, 1);
   add_vec("wr_unmapped_gap", 1, 0, 32'h0001_8008, 64'h9999_8888_7777_6666, 8'hFF, '0, 1);
   add_vec("rd_beyond_last",  0, 0, 32'h0003_0000, '0, 8'hFF, '0, 1);
   add_vec("wr_beyond_last",  1, 0, 32'h0010_0000, 64'h4444_3333_2222_1111, 8'hFF, '0, 1);
   add_vec("rd_after_miss",   0, 0, 32'h0000_0010, '0, 8'hFF, 64'h0123_4567_89AB_CDEF, 0);
endtask

`endif

/* sim/tb_bram_io.sv */
// testbench for the banked block RAM: clock, reset, table loop, shadow model, checks, summary

`timescale 1ns/1ns

module tb_bram_io;

   import bram_io_pkg::*;

   `include "tb_vectors.svh"

   logic    ram_clk;
   logic    rst_i;
   logic    wb_cyc;
   logic    wb_stb;
   logic    wb_we;
   wb_adr_t wb_adr;
   wb_dat_t wb_dat;
   wb_sel_t wb_sel;
   logic    wb_ack_o;
   logic    wb_err_o;
   wb_dat_t wb_dat_o;

   integer  seed;
   int      err_count;
   int      test_count;
   int      fail_tests;

   // expected memory contents, one entry per bus word
   wb_dat_t shadow [logic [28:0]];

   bram_io_top UUT (
      .ram_clk  ( ram_clk  ),
      .rst_i    ( rst_i    ),
      .wb_cyc_i ( wb_cyc   ),
      .wb_stb_i ( wb_stb   ),
      .wb_we_i  ( wb_we    ),
      .wb_adr_i ( wb_adr   ),
      .wb_dat_i ( wb_dat   ),
      .wb_sel_i ( wb_sel   ),
      .wb_ack_o ( wb_ack_o ),
      .wb_err_o ( wb_err_o ),
      .wb_dat_o ( wb_dat_o )
   );

   initial begin
      ram_clk = 1'b0;
      forever #(CLK_PERIOD/2) ram_clk = ~ram_clk;
   end

   ////////////////////
   // helpers

   task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
         err_count++;
      end
   endtask

   // selected bytes come from the new word, the rest stay
   function automatic wb_dat_t merge_bytes(input wb_dat_t old_dat, input wb_dat_t new_dat,
                                           input wb_sel_t sel);
      wb_dat_t res;
      res = old_dat;
      for (int b = 0; b < DAT_BYTES; b++) begin
         if (sel[b]) begin
            res[b*8 +: 8] = new_dat[b*8 +: 8];
         end
      end
      return res;
   endfunction

   task automatic report_test(input string name, input int errs_before);
      test_count++;
      if (err_count != errs_before) begin
         fail_tests++;
         $display("test %s failed", name);
      end else begin
         $display("test %s ok", name);
      end
   endtask

   ////////////////////
   // one table entry

   task automatic run_vector(input int idx, output bit timed_out);
      wb_dat_t     data;
      wb_dat_t     expect_dat;
      wb_dat_t     old_dat;
      logic [28:0] key;
      int          cycles;
      bit          got;
      int          errs_before;

      errs_before = err_count;
      timed_out   = 1'b0;
      key         = vec_adr[idx][31:3];
      data        = vec_dat[idx];
      expect_dat  = vec_exp[idx];
      if (vec_rnd[idx] && vec_we[idx]) begin
         data = {$random(seed), $random(seed)};
      end
      if (vec_rnd[idx] && !vec_we[idx]) begin
         expect_dat = shadow.exists(key) ? shadow[key] : '0;
      end
      if (vec_we[idx] && !vec_err[idx]) begin
         old_dat     = shadow.exists(key) ? shadow[key] : '0;
         shadow[key] = merge_bytes(old_dat, data, vec_sel[idx]);
      end

      @(posedge ram_clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we  <= vec_we[idx];
      wb_adr <= vec_adr[idx];
      wb_dat <= data;
      wb_sel <= vec_sel[idx];

      cycles = 0;
      got    = 1'b0;
      while (!got && cycles < RESP_TIMEOUT) begin
         @(negedge ram_clk);
         cycles++;
         got = wb_ack_o | wb_err_o;
      end

      if (!got) begin
         $display("%0t ns: no response from the DUT for test %s within %0d cycles",
                  $time, vec_name[idx], RESP_TIMEOUT);
         err_count++;
         timed_out = 1'b1;
      end else begin
         check_val({vec_name[idx], " latency"}, 64'(cycles), 64'(RESP_LATENCY));
         check_val({vec_name[idx], " ack"}, 64'(wb_ack_o), 64'(!vec_err[idx]));
         check_val({vec_name[idx], " err"}, 64'(wb_err_o), 64'(vec_err[idx]));
         if (!vec_we[idx] && !vec_err[idx]) begin
            check_val({vec_name[idx], " read data"}, wb_dat_o, expect_dat);
         end
      end

      // stb is still seen at this edge, the response must drop regardless
      @(posedge ram_clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      @(negedge ram_clk);
      if (got) begin
         check_val({vec_name[idx], " ack pulse width"}, 64'(wb_ack_o), 64'd0);
         check_val({vec_name[idx], " err pulse width"}, 64'(wb_err_o), 64'd0);
      end

      report_test(vec_name[idx], errs_before);
   endtask

   ////////////////////
   // main sequence

   initial begin
      bit timed_out;
      int errs_before;

      seed       = SEED_INIT;
      err_count  = 0;
      test_count = 0;
      fail_tests = 0;
      timed_out  = 1'b0;

      rst_i  = 1'b1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      wb_adr = '0;
      wb_dat = '0;
      wb_sel = '0;

      load_vectors();

      // a request held through reset must get no response
      errs_before = err_count;
      for (int c = 0; c < RST_CYCLES; c++) begin
         @(posedge ram_clk);
         wb_cyc <= (c < RST_CYCLES-1);
         wb_stb <= (c < RST_CYCLES-1);
         wb_adr <= c[0] ? 32'h0000_1000 : 32'h0000_0000;   // mapped, then unmapped
         if (c == RST_CYCLES-1) begin
            rst_i <= 1'b0;
         end
         @(negedge ram_clk);
         check_val("ack in reset", 64'(wb_ack_o), 64'd0);
         check_val("err in reset", 64'(wb_err_o), 64'd0);
      end
      report_test("reset", errs_before);

      for (int i = 0; i < vec_name.size(); i++) begin
         run_vector(i, timed_out);
         if (timed_out) begin
            break;
         end
      end

      $display("tests run %0d, tests failed %0d, check errors %0d",
               test_count, fail_tests, err_count);
      if (err_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* verilog.f */
+incdir+sim
hdl/bram_io_pkg.sv
hdl/io_addr_decoder.sv
hdl/bram_bank.sv
hdl/io_resp_mux.sv
hdl/bram_io_top.sv
sim/tb_bram_io.sv
